// File: bench/exec_core_properties.sv
// Execute slice assertions: memory enables, sticky halt and writeback target
`timescale 1ns/10ps

module exec_core_properties (
  input logic       clk_i,
  input logic       reset_i,
  input logic       instr_valid_i,
  input logic       dren_i,
  input logic       dwen_i,
  input logic       wb_en_i,
  input logic [4:0] wb_rd_i,
  input logic       halt_i
);

  // Memory access only for a presented instruction
  mem_needs_valid: assert property (
    @(posedge clk_i) disable iff (reset_i) (dren_i || dwen_i) |-> instr_valid_i
  ) else $error("memory enable raised without instr_valid_i");

  halt_sticky: assert property (
    @(posedge clk_i) disable iff (reset_i) halt_i |=> halt_i
  ) else $error("halt_o dropped before reset");

  // x0 is never a write target
  wb_not_x0: assert property (
    @(posedge clk_i) disable iff (reset_i) wb_en_i |-> (wb_rd_i != 5'd0)
  ) else $error("wb_en_o set while wb_rd_o is zero");

endmodule

bind exec_core exec_core_properties u_props (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .instr_valid_i(instr_valid_i),
  .dren_i(dren_o),
  .dwen_i(dwen_o),
  .wb_en_i(wb_en_o),
  .wb_rd_i(wb_rd_o),
  .halt_i(halt_o)
);

// File: bench/exec_core_tb.sv
// Testbench for the RV32I execute slice with table-driven instruction checks and halt behavior
`timescale 1ns/10ps

module exec_core_tb
  import rv32i_pkg::*;
();

  localparam logic [31:0] LOAD_WORD = 32'h80f4_7f85;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] dload;
    logic [31:0] wb_en;
    logic [31:0] wb_rd;
    logic [31:0] wb_data;
    logic [31:0] next_pc;
    logic [31:0] dren;
    logic [31:0] dwen;
    logic [31:0] daddr;
    logic [31:0] byte_en;
    logic [31:0] dwdata;
  } row_t;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic [31:0] pc_i;
  logic [31:0] dload_data_i;
  logic [31:0] daddr_o, dwdata_o, wb_data_o, next_pc_o;
  logic [3:0]  byte_en_o;
  logic [4:0]  wb_rd_o;
  logic        dren_o, dwen_o, wb_en_o, halt_o;

  row_t rows[$];
  int   row_idx;

  exec_core uut (.*);

  always #4 clk_i = ~clk_i;

  // Instruction encoders for each RV32I format
  function automatic logic [31:0] r_enc(input int f7, input int f3, input int rd,
                                        input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], REGREG};
  endfunction

  function automatic logic [31:0] i_enc(input int f3, input int rd, input int rs1,
                                        input int imm, input opcode_t op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] s_enc(input int f3, input int rs2, input int rs1,
                                        input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], STORE};
  endfunction

  function automatic logic [31:0] b_enc(input int f3, input int rs1, input int rs2,
                                        input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic logic [31:0] u_enc(input int rd, input int imm, input opcode_t op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] j_enc(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], JAL};
  endfunction

  function automatic void add_row(input logic [31:0] instr, pc, dload, wb_en, wb_rd, wb_data,
                                  input logic [31:0] next_pc, dren, dwen, daddr, byte_en,
                                  input logic [31:0] dwdata);
    row_t r;
    r = '{instr, pc, dload, wb_en, wb_rd, wb_data, next_pc, dren, dwen, daddr, byte_en,
          dwdata};
    rows.push_back(r);
  endfunction

  function automatic void alu_row(input logic [31:0] instr, pc, wb_en, rd, data);
    add_row(instr, pc, 0, wb_en, rd, data, pc + 4, 0, 0, 0, 0, 0);
  endfunction

  function automatic void load_row(input logic [31:0] instr, pc, rd, data, addr, be);
    add_row(instr, pc, LOAD_WORD, 1, rd, data, pc + 4, 1, 0, addr, be, 0);
  endfunction

  function automatic void store_row(input logic [31:0] instr, pc, addr, be, data);
    add_row(instr, pc, 0, 0, 0, 0, pc + 4, 0, 1, addr, be, data);
  endfunction

  function automatic void flow_row(input logic [31:0] instr, pc, wb_en, rd, data, next_pc);
    add_row(instr, pc, 0, wb_en, rd, data, next_pc, 0, 0, 0, 0, 0);
  endfunction

  task automatic build_table();
    // Immediate arithmetic and compares
    alu_row(i_enc(ADDI, 1, 0, 5, IMMED), 'h100, 1, 1, 'h0000_0005);
    alu_row(i_enc(ADDI, 2, 0, -3, IMMED), 'h104, 1, 2, 'hffff_fffd);
    alu_row(i_enc(SLTI, 3, 2, 1, IMMED), 'h108, 1, 3, 'h0000_0001);
    alu_row(i_enc(SLTIU, 4, 2, 1, IMMED), 'h10c, 1, 4, 'h0000_0000);
    alu_row(i_enc(XORI, 5, 1, 'h0f0, IMMED), 'h110, 1, 5, 'h0000_00f5);
    alu_row(i_enc(ORI, 6, 1, 'h700, IMMED), 'h114, 1, 6, 'h0000_0705);
    alu_row(i_enc(ANDI, 7, 2, 'h0ff, IMMED), 'h118, 1, 7, 'h0000_00fd);
    // Register ops on x1 = 5 and x2 = -3
    alu_row(r_enc(0, ADDSUB, 8, 1, 2), 'h11c, 1, 8, 'h0000_0002);
    alu_row(r_enc('h20, ADDSUB, 9, 1, 2), 'h120, 1, 9, 'h0000_0008);
    // SLL shifts by 16 because x10 holds 0x50
    alu_row(i_enc(SLLI, 10, 1, 4, IMMED), 'h124, 1, 10, 'h0000_0050);
    alu_row(i_enc(SRI, 11, 2, 4, IMMED), 'h128, 1, 11, 'h0fff_ffff);
    alu_row(i_enc(SRI, 12, 2, 'h401, IMMED), 'h12c, 1, 12, 'hffff_fffe);
    alu_row(r_enc(0, SLL, 13, 1, 10), 'h130, 1, 13, 'h0005_0000);
    alu_row(r_enc(0, SR, 14, 2, 1), 'h134, 1, 14, 'h07ff_ffff);
    alu_row(r_enc('h20, SR, 15, 2, 1), 'h138, 1, 15, 'hffff_ffff);
    alu_row(r_enc(0, SLT, 16, 2, 1), 'h13c, 1, 16, 'h0000_0001);
    alu_row(r_enc(0, SLTU, 17, 2, 1), 'h140, 1, 17, 'h0000_0000);
    // Upper immediates and a write to x0 before x0 is read
    alu_row(u_enc(18, 'h12345, LUI), 'h144, 1, 18, 'h1234_5000);
    alu_row(u_enc(19, 'h00010, AUIPC), 'h148, 1, 19, 'h0001_0148);
    alu_row(i_enc(ADDI, 0, 1, 7, IMMED), 'h14c, 0, 0, 'h0000_0000);
    alu_row(r_enc(0, ADDSUB, 20, 0, 8), 'h150, 1, 20, 'h0000_0002);
    alu_row(u_enc(21, 'h00001, LUI), 'h154, 1, 21, 'h0000_1000);
    // Loads from base 0x1000 with memory word 80f47f85
    load_row(i_enc(LB, 22, 21, 0, LOAD), 'h158, 22, 'hffff_ff85, 'h1000, 'b0001);
    load_row(i_enc(LB, 22, 21, 1, LOAD), 'h15c, 22, 'h0000_007f, 'h1001, 'b0010);
    load_row(i_enc(LB, 22, 21, 2, LOAD), 'h160, 22, 'hffff_fff4, 'h1002, 'b0100);
    load_row(i_enc(LB, 22, 21, 3, LOAD), 'h164, 22, 'hffff_ff80, 'h1003, 'b1000);
    load_row(i_enc(LBU, 23, 21, 0, LOAD), 'h168, 23, 'h0000_0085, 'h1000, 'b0001);
    load_row(i_enc(LBU, 23, 21, 1, LOAD), 'h16c, 23, 'h0000_007f, 'h1001, 'b0010);
    load_row(i_enc(LBU, 23, 21, 2, LOAD), 'h170, 23, 'h0000_00f4, 'h1002, 'b0100);
    load_row(i_enc(LBU, 23, 21, 3, LOAD), 'h174, 23, 'h0000_0080, 'h1003, 'b1000);
    load_row(i_enc(LH, 25, 21, 0, LOAD), 'h178, 25, 'h0000_7f85, 'h1000, 'b0011);
    load_row(i_enc(LH, 25, 21, 2, LOAD), 'h17c, 25, 'hffff_80f4, 'h1002, 'b1100);
    load_row(i_enc(LHU, 26, 21, 0, LOAD), 'h180, 26, 'h0000_7f85, 'h1000, 'b0011);
    load_row(i_enc(LHU, 26, 21, 2, LOAD), 'h184, 26, 'h0000_80f4, 'h1002, 'b1100);
    load_row(i_enc(LW, 24, 21, 0, LOAD), 'h188, 24, 'h80f4_7f85, 'h1000, 'b1111);
    // SB, SH and SW use the load funct3 values and put x1 on its byte lanes
    store_row(s_enc(LB, 1, 21, 1), 'h18c, 'h1001, 'b0010, 'h0000_0500);
    store_row(s_enc(LH, 1, 21, 2), 'h190, 'h1002, 'b1100, 'h0005_0000);
    store_row(s_enc(LW, 1, 21, 0), 'h194, 'h1000, 'b1111, 'h0000_0005);
    // Each condition taken and then not taken
    flow_row(b_enc(BEQ, 1, 1, -16), 'h198, 0, 0, 0, 'h188);
    flow_row(b_enc(BEQ, 1, 2, 'h20), 'h19c, 0, 0, 0, 'h1a0);
    flow_row(b_enc(BNE, 1, 2, 'h20), 'h1a0, 0, 0, 0, 'h1c0);
    flow_row(b_enc(BNE, 1, 1, 'h20), 'h1a4, 0, 0, 0, 'h1a8);
    flow_row(b_enc(BLT, 2, 1, 'h20), 'h1a8, 0, 0, 0, 'h1c8);
    flow_row(b_enc(BLT, 1, 2, 'h20), 'h1ac, 0, 0, 0, 'h1b0);
    flow_row(b_enc(BGE, 1, 2, 'h20), 'h1b0, 0, 0, 0, 'h1d0);
    flow_row(b_enc(BGE, 2, 1, 'h20), 'h1b4, 0, 0, 0, 'h1b8);
    flow_row(b_enc(BLTU, 1, 2, 'h20), 'h1b8, 0, 0, 0, 'h1d8);
    flow_row(b_enc(BLTU, 2, 1, 'h20), 'h1bc, 0, 0, 0, 'h1c0);
    flow_row(b_enc(BGEU, 2, 1, 'h20), 'h1c0, 0, 0, 0, 'h1e0);
    flow_row(b_enc(BGEU, 1, 2, 'h20), 'h1c4, 0, 0, 0, 'h1c8);
    // JALR target 5 + 0x10 loses bit 0
    flow_row(j_enc(27, 'h100), 'h1c8, 1, 27, 'h0000_01cc, 'h2c8);
    flow_row(i_enc(0, 28, 1, 'h10, JALR), 'h1cc, 1, 28, 'h0000_01d0, 'h014);
    alu_row(r_enc(0, ADDSUB, 29, 27, 28), 'h1d0, 1, 29, 'h0000_039c);
    alu_row(i_enc(ADDI, 30, 24, 0, IMMED), 'h1d4, 1, 30, 'h80f4_7f85);
    flow_row(HALT_INSTR, 'h1d8, 0, 0, 0, 'h1dc);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s is 0x%08h, expected 0x%08h (row %0d)", name, got, exp, row_idx);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_row(input row_t r);
    check_value("wb_en_o", 32'(wb_en_o), r.wb_en);
    check_value("wb_rd_o", 32'(wb_rd_o), r.wb_rd);
    check_value("wb_data_o", wb_data_o, r.wb_data);
    check_value("next_pc_o", next_pc_o, r.next_pc);
    check_value("dren_o", 32'(dren_o), r.dren);
    check_value("dwen_o", 32'(dwen_o), r.dwen);
    check_value("daddr_o", daddr_o, r.daddr);
    check_value("byte_en_o", 32'(byte_en_o), r.byte_en);
    check_value("dwdata_o", dwdata_o, r.dwdata);
    check_value("halt_o", 32'(halt_o), 32'd0);
  endtask

  task automatic apply_instr(input logic [31:0] instr, input logic [31:0] pc,
                             input logic [31:0] dload);
    instr_valid_i = 1'b1;
    instr_i       = instr;
    pc_i          = pc;
    dload_data_i  = dload;
  endtask

  initial begin
    int          waited;
    logic [31:0] late [3];
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    dload_data_i  = '0;
    build_table();
    late[0] = i_enc(ADDI, 1, 1, 1, IMMED);
    late[1] = i_enc(LW, 24, 21, 0, LOAD);
    late[2] = s_enc(LW, 1, 21, 0);
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // One row per cycle sampled 1 ns before the next edge
    for (int i = 0; i < rows.size(); i++) begin
      row_idx = i;
      apply_instr(rows[i].instr, rows[i].pc, rows[i].dload);
      #6;
      check_row(rows[i]);
      @(posedge clk_i);
      #1;
    end

    // Last row was the halt instruction
    instr_valid_i = 1'b0;
    waited = 0;
    while (!halt_o && waited < 16) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (!halt_o) begin
      $display("Timeout: halt_o never rose after the halt instruction");
      $display("SOME TESTS FAILED");
      $fatal(1, "halt timeout");
    end

    // Halted core must ignore valid instructions
    for (int i = 0; i < 3; i++) begin
      row_idx = rows.size() + i;
      apply_instr(late[i], 'h200 + 4 * i, LOAD_WORD);
      #6;
      check_value("wb_en_o", 32'(wb_en_o), 32'd0);
      check_value("dren_o", 32'(dren_o), 32'd0);
      check_value("dwen_o", 32'(dwen_o), 32'd0);
      check_value("byte_en_o", 32'(byte_en_o), 32'd0);
      check_value("halt_o", 32'(halt_o), 32'd1);
      @(posedge clk_i);
      #1;
    end
    instr_valid_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_value("halt_o", 32'(halt_o), 32'd1);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: logic/alu.sv
// RV32I ALU with a separate comparator for branch conditions
`timescale 1ns/10ps

module alu
  import rv32i_pkg::*;
(
  input  alu_op_t         alu_op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  input  branch_t         branch_type_i,
  output logic [XLEN-1:0] result_o,
  output logic            branch_taken_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
      default:  result_o = a_i + b_i;
    endcase
  end

  // Compare register values, not the muxed operands
  always_comb begin
    case (branch_type_i)
      BEQ:     branch_taken_o = (rs1_data_i == rs2_data_i);
      BNE:     branch_taken_o = (rs1_data_i != rs2_data_i);
      BLT:     branch_taken_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
      BGE:     branch_taken_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      BLTU:    branch_taken_o = (rs1_data_i < rs2_data_i);
      BGEU:    branch_taken_o = (rs1_data_i >= rs2_data_i);
      default: branch_taken_o = 1'b0;
    endcase
  end

endmodule

// File: logic/control_unit.sv
// RV32I control unit: combinational decode of one instruction into datapath controls
`timescale 1ns/10ps

module control_unit
  import rv32i_pkg::*;
(
  input  logic [31:0]           instr_i,
  input  logic [1:0]            byte_offset_i,
  output opcode_t               opcode_o,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic [XLEN-1:0]       imm_i_o,
  output logic [XLEN-1:0]       imm_s_o,
  output logic [XLEN-1:0]       imm_sb_o,
  output logic [XLEN-1:0]       imm_uj_o,
  output logic [XLEN-1:0]       imm_u_o,
  output logic                  imm_shamt_sel_o,
  output alu_a_sel_t            alu_a_sel_o,
  output alu_b_sel_t            alu_b_sel_o,
  output w_sel_t                w_sel_o,
  output load_t                 load_type_o,
  output branch_t               branch_type_o,
  output logic [3:0]            byte_en_o,
  output logic                  dren_o,
  output logic                  dwen_o,
  output logic                  branch_o,
  output logic                  jump_o,
  output logic                  j_sel_o,
  output logic                  wen_o,
  output alu_op_t               alu_op_o,
  output logic                  halt_o
);

  logic [2:0] funct3;
  logic       bit30;

  assign funct3   = instr_i[14:12];
  assign bit30    = instr_i[30];
  assign opcode_o = opcode_t'(instr_i[6:0]);
  assign rs1_o    = instr_i[19:15];
  assign rs2_o    = instr_i[24:20];
  assign rd_o     = instr_i[11:7];

  // Immediates, all sign-extended from bit 31
  assign imm_i_o  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_o  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
  assign imm_uj_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
  assign imm_u_o  = {instr_i[31:12], 12'b0};

  assign imm_shamt_sel_o = (opcode_o == IMMED) &&
                           (funct3 == SLLI || funct3 == SRI);

  assign load_type_o   = load_t'(funct3);
  assign branch_type_o = branch_t'(funct3);

  // Lane enables, shared by loads and stores
  always_comb begin
    case (load_type_o)
      LB, LBU: byte_en_o = 4'b0001 << byte_offset_i;
      LH, LHU: begin
        case (byte_offset_i)
          2'b00:   byte_en_o = 4'b0011;
          2'b10:   byte_en_o = 4'b1100;
          default: byte_en_o = 4'b0000;
        endcase
      end
      LW:      byte_en_o = (byte_offset_i == 2'b00) ? 4'b1111 : 4'b0000;
      default: byte_en_o = 4'b0000;
    endcase
  end

  assign dren_o   = (opcode_o == LOAD);
  assign dwen_o   = (opcode_o == STORE);
  assign branch_o = (opcode_o == BRANCH);
  assign jump_o   = (opcode_o == JAL) || (opcode_o == JALR);
  assign j_sel_o  = (opcode_o == JAL);

  always_comb begin
    alu_a_sel_o = A_RS1;
    alu_b_sel_o = B_IMM_I;
    w_sel_o     = W_LOAD;
    wen_o       = 1'b0;
    case (opcode_o)
      REGREG: begin
        alu_b_sel_o = B_RS2;
        w_sel_o     = W_ALU;
        wen_o       = 1'b1;
      end
      IMMED: begin
        alu_a_sel_o = A_RS1_I;
        w_sel_o     = W_ALU;
        wen_o       = 1'b1;
      end
      LOAD: begin
        alu_a_sel_o = A_RS1_I;
        wen_o       = 1'b1;
      end
      STORE:  alu_b_sel_o = B_IMM_S;
      AUIPC: begin
        alu_a_sel_o = A_PC;
        alu_b_sel_o = B_IMM_U;
        w_sel_o     = W_ALU;
        wen_o       = 1'b1;
      end
      LUI: begin
        w_sel_o = W_IMM_U;
        wen_o   = 1'b1;
      end
      JAL: begin
        w_sel_o = W_LINK;
        wen_o   = 1'b1;
      end
      // JALR target is rs1 + imm_I through the ALU
      JALR: begin
        alu_a_sel_o = A_RS1_I;
        w_sel_o     = W_LINK;
        wen_o       = 1'b1;
      end
      default: ;
    endcase
  end

  // ALU op from opcode, funct3 and bit 30
  always_comb begin
    alu_op_o = ALU_ADD;
    if (opcode_o == IMMED || opcode_o == REGREG) begin
      case (funct3)
        3'b000:  alu_op_o = (opcode_o == REGREG && bit30) ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op_o = ALU_SLL;
        3'b010:  alu_op_o = ALU_SLT;
        3'b011:  alu_op_o = ALU_SLTU;
        3'b100:  alu_op_o = ALU_XOR;
        3'b101:  alu_op_o = bit30 ? ALU_SRA : ALU_SRL;
        3'b110:  alu_op_o = ALU_OR;
        default: alu_op_o = ALU_AND;
      endcase
    end
  end

  assign halt_o = (instr_i == HALT_INSTR);

endmodule

// File: logic/exec_core.sv
// Single-cycle RV32I decode/execute slice: operands, writeback, next PC and halt
`timescale 1ns/10ps

module exec_core
  import rv32i_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  logic [31:0]           instr_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       dload_data_i,
  output logic [XLEN-1:0]       daddr_o,
  output logic [XLEN-1:0]       dwdata_o,
  output logic [3:0]            byte_en_o,
  output logic                  dren_o,
  output logic                  dwen_o,
  output logic                  wb_en_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o,
  output logic [XLEN-1:0]       next_pc_o,
  output logic                  halt_o
);

  opcode_t               opcode;
  logic [REG_ADDR_W-1:0] rs1, rs2, rd;
  logic [XLEN-1:0]       imm_i, imm_s, imm_sb, imm_uj, imm_u;
  logic                  imm_shamt_sel, dren, dwen, branch, jump, j_sel, wen, halt_instr;
  alu_a_sel_t            alu_a_sel;
  alu_b_sel_t            alu_b_sel;
  w_sel_t                w_sel;
  load_t                 load_type;
  branch_t               branch_type;
  alu_op_t               alu_op;
  logic [3:0]            byte_en;
  logic [XLEN-1:0]       rs1_data, rs2_data, alu_a, alu_b, alu_result;
  logic [XLEN-1:0]       load_shifted, load_value, wdata, pc_plus4;
  logic [1:0]            byte_offset;
  logic                  branch_taken, live, mem_req;

  control_unit u_control (
    .instr_i(instr_i), .byte_offset_i(byte_offset), .opcode_o(opcode),
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_i_o(imm_i), .imm_s_o(imm_s),
    .imm_sb_o(imm_sb), .imm_uj_o(imm_uj), .imm_u_o(imm_u),
    .imm_shamt_sel_o(imm_shamt_sel), .alu_a_sel_o(alu_a_sel), .alu_b_sel_o(alu_b_sel),
    .w_sel_o(w_sel), .load_type_o(load_type), .branch_type_o(branch_type),
    .byte_en_o(byte_en), .dren_o(dren), .dwen_o(dwen), .branch_o(branch),
    .jump_o(jump), .j_sel_o(j_sel), .wen_o(wen), .alu_op_o(alu_op), .halt_o(halt_instr)
  );

  reg_file u_regs (
    .clk_i(clk_i), .reset_i(reset_i), .wen_i(wb_en_o), .rd_i(rd), .wdata_i(wdata),
    .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  alu u_alu (
    .alu_op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data), .branch_type_i(branch_type), .result_o(alu_result),
    .branch_taken_o(branch_taken)
  );

  // Nothing issues once halted
  assign live        = instr_valid_i && !halt_o;
  assign byte_offset = alu_result[1:0];
  assign pc_plus4    = pc_i + 32'd4;

  always_comb begin
    case (alu_a_sel)
      A_PC:    alu_a = pc_i;
      default: alu_a = rs1_data;
    endcase
    case (alu_b_sel)
      B_RS2:   alu_b = rs2_data;
      B_IMM_S: alu_b = imm_s;
      B_IMM_U: alu_b = imm_u;
      // Shift amount sits in the rs2 field
      default: alu_b = imm_shamt_sel ? {27'b0, rs2} : imm_i;
    endcase
  end

  // Load lane moved down to bit 0 before extension
  assign load_shifted = dload_data_i >> {byte_offset, 3'b000};

  always_comb begin
    case (load_type)
      LB:      load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
      LBU:     load_value = {24'b0, load_shifted[7:0]};
      LH:      load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
      LHU:     load_value = {16'b0, load_shifted[15:0]};
      default: load_value = dload_data_i;
    endcase
    case (w_sel)
      W_LOAD:  wdata = load_value;
      W_LINK:  wdata = pc_plus4;
      W_IMM_U: wdata = imm_u;
      default: wdata = alu_result;
    endcase
  end

  assign dren_o    = live && dren;
  assign dwen_o    = live && dwen;
  assign mem_req   = dren_o || dwen_o;
  assign daddr_o   = mem_req ? alu_result : '0;
  assign byte_en_o = mem_req ? byte_en : 4'b0000;
  // Store data placed on its byte lanes
  assign dwdata_o  = (opcode == STORE) ? (rs2_data << {byte_offset, 3'b000}) : '0;

  assign wb_en_o   = live && wen && (rd != '0);
  assign wb_rd_o   = wb_en_o ? rd : '0;
  assign wb_data_o = wb_en_o ? wdata : '0;

  always_comb begin
    if (branch && branch_taken) begin
      next_pc_o = pc_i + imm_sb;
    end else if (jump) begin
      next_pc_o = j_sel ? (pc_i + imm_uj) : {alu_result[XLEN-1:1], 1'b0};
    end else begin
      next_pc_o = pc_plus4;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      halt_o <= 1'b0;
    end else if (live && halt_instr) begin
      halt_o <= 1'b1;
    end
  end

endmodule

// File: logic/reg_file.sv
// Integer register file: 32 x 32 bits, two async read ports, one write port
`timescale 1ns/10ps

module reg_file (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        wen_i,
  input  logic [4:0]  rd_i,
  input  logic [31:0] wdata_i,
  input  logic [4:0]  rs1_i,
  input  logic [4:0]  rs2_i,
  output logic [31:0] rs1_data_o,
  output logic [31:0] rs2_data_o
);

  logic [31:0] regs [32];

  // x0 never takes a write so it holds zero after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

endmodule

// File: logic/rv32i_pkg.sv
// RV32I shared encodings: opcodes, funct3 groups, ALU ops, datapath selects
package rv32i_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Halt is a fixed SYSTEM encoding until traps exist
  localparam logic [31:0] HALT_INSTR = 32'h7800d073;

  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_t;

  // Stores reuse these funct3 values for SB, SH and SW
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    ADDI  = 3'b000,
    SLLI  = 3'b001,
    SLTI  = 3'b010,
    SLTIU = 3'b011,
    XORI  = 3'b100,
    SRI   = 3'b101,
    ORI   = 3'b110,
    ANDI  = 3'b111
  } imm_funct3_t;

  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } reg_funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // Both RS1 codes pick rs1 data in the datapath
  typedef enum logic [1:0] {A_RS1 = 2'd0, A_RS1_I = 2'd1, A_PC = 2'd2} alu_a_sel_t;
  typedef enum logic [1:0] {B_IMM_I = 2'd0, B_RS2 = 2'd1, B_IMM_S = 2'd2, B_IMM_U = 2'd3} alu_b_sel_t;
  typedef enum logic [1:0] {W_LOAD = 2'd0, W_LINK = 2'd1, W_IMM_U = 2'd2, W_ALU = 2'd3} w_sel_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps -f verilog.f \
  --top-module exec_core_tb -o exec_core_sim

sim_out=$(./obj_dir/exec_core_sim 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// File: verilog.f
logic/rv32i_pkg.sv
logic/control_unit.sv
logic/reg_file.sv
logic/alu.sv
logic/exec_core.sv
bench/exec_core_properties.sv
bench/exec_core_tb.sv
